//--- hdl/mul_if.sv
interface mul_if;
  import redun_mont_pkg::*;

  mult_ctl_t ctl;
  redun0_t   dat_a;
  redun0_t   dat_b;
  redun0_t   add_term;
  redun1_t   dat;

  // Sequencer side, drives operands and mode
  modport seq (
    output ctl, dat_a, dat_b, add_term,
    input  dat
  );

  // Multiplier side, returns the registered product
  modport mult (
    input  ctl, dat_a, dat_b, add_term,
    output dat
  );

endinterface

//--- hdl/multi_mode_multiplier.sv
`include "redun_mont_defs.svh"

module multi_mode_multiplier (
  input logic i_clk,
  mul_if.mult mul
);
  import redun_mont_pkg::*;

  localparam int W = `RM_WRD_BITS;
  localparam int N = `RM_NUM_WRDS;
  // Room for N products of two full words plus the add term
  localparam int COL_BITS = 2 * W + 2 + $clog2(N + 1);

  logic [COL_BITS-1:0] col [2*N];
  logic [W+1:0] part [2*N];
  redun1_t prod;

  // Column sums of the word-wise partial products
  always_comb begin
    for (int k = 0; k < 2 * N; k++) begin
      col[k] = '0;
    end
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        col[i+j] = col[i+j] + COL_BITS'(mul.dat_a[i]) * COL_BITS'(mul.dat_b[j]);
      end
    end
    // High half product picks up the add term in the upper words
    if (mul.ctl == MUL_H) begin
      for (int k = 0; k < N; k++) begin
        col[N+k] = col[N+k] + COL_BITS'(mul.add_term[k]);
      end
    end
  end

  // Two shallow folds, each word only sees its near neighbours
  always_comb begin
    for (int k = 0; k < 2 * N; k++) begin
      part[k] = (W+2)'(col[k][W-1:0]);
    end
    for (int k = 1; k < 2 * N; k++) begin
      part[k] = part[k] + (W+2)'(col[k-1][2*W-1:W]);
    end
    for (int k = 2; k < 2 * N; k++) begin
      part[k] = part[k] + (W+2)'(col[k-2][COL_BITS-1:2*W]);
    end

    // Second fold leaves at most one carry bit per word
    for (int k = 0; k < 2 * N; k++) begin
      prod[k] = wrd_t'(part[k][W-1:0]);
    end
    for (int k = 1; k < 2 * N; k++) begin
      prod[k] = prod[k] + wrd_t'(part[k-1][W+1:W]);
    end

    // Low product only, upper words cleared
    if (mul.ctl == MUL_L) begin
      for (int k = N; k < 2 * N; k++) begin
        prod[k] = '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    mul.dat <= prod;
  end

endmodule

//--- hdl/redun_equalizer.sv
`include "redun_mont_defs.svh"

module redun_equalizer (
  input  logic                    i_clk,
  input  redun_mont_pkg::redun1_t i_dat,
  output redun_mont_pkg::redun1_t o_dat,
  output redun_mont_pkg::fe_t     o_low
);

  localparam int W  = `RM_WRD_BITS;
  localparam int NW = 2 * `RM_NUM_WRDS;

  logic [NW*W-1:0] dat_bits;
  logic [NW*W-1:0] cry_bits;
  logic [NW*W-1:0] sum;

  // Word bits and carry bits as two binary vectors, then one add
  always_comb begin
    dat_bits = '0;
    cry_bits = '0;
    for (int k = 0; k < NW; k++) begin
      dat_bits[k*W +: W] = i_dat[k][W-1:0];
    end
    // Carry of word k belongs to bit 0 of word k+1
    for (int k = 0; k < NW - 1; k++) begin
      cry_bits[(k+1)*W] = i_dat[k][W];
    end
    sum = dat_bits + cry_bits;
  end

  always_ff @(posedge i_clk) begin
    for (int k = 0; k < NW; k++) begin
      o_dat[k] <= {1'b0, sum[k*W +: W]};
    end
    o_low <= sum[`RM_DAT_BITS-1:0];
  end

endmodule

//--- hdl/redun_mont.sv
`include "redun_mont_defs.svh"

module redun_mont (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  redun_mont_pkg::fe_t     i_sq,
  input  logic                    i_val,
  mul_if.seq                      mul,
  input  redun_mont_pkg::redun1_t i_eq_dat,
  input  redun_mont_pkg::fe_t     i_eq_low,
  output redun_mont_pkg::redun1_t o_eq_dat,
  output redun_mont_pkg::fe_t     o_mul,
  output logic                    o_val
);
  import redun_mont_pkg::*;

  localparam int W = `RM_WRD_BITS;
  localparam int N = `RM_NUM_WRDS;
  localparam int CNT_BITS = $clog2(`RM_ITER_CYCLES);
  // Cycle offsets from the square issue
  localparam int CNT_MUL1 = 2;
  localparam int CNT_MUL2 = 4;
  localparam int CNT_LAST = `RM_ITER_CYCLES - 1;

  typedef enum logic [4:0] {
    IDLE  = 5'b00001,
    START = 5'b00010,
    MUL0  = 5'b00100,
    MUL1  = 5'b01000,
    MUL2  = 5'b10000
  } state_t;

  state_t state_q;
  state_t state_d;
  logic [CNT_BITS-1:0] cnt_q;
  logic val_q;
  logic done;
  fe_t sq_q;
  fe_t op_q;
  fe_t res;
  redun0_t add_q;
  logic [W*N:0] lo_sum;

  // Product goes straight to the equalizer
  assign o_eq_dat = mul.dat;

  // A registered i_val restarts the loop from any state
  always_comb begin
    state_d = state_q;
    if (val_q) begin
      state_d = START;
    end else begin
      unique case (state_q)
        IDLE:  state_d = IDLE;
        START: state_d = MUL0;
        MUL0:  state_d = MUL1;
        MUL1: begin
          if (cnt_q == CNT_BITS'(CNT_MUL2 - 1)) begin
            state_d = MUL2;
          end
        end
        MUL2: begin
          if (cnt_q == CNT_BITS'(CNT_LAST)) begin
            state_d = START;
          end
        end
        default: state_d = IDLE;
      endcase
    end
  end

  assign done = (state_q == MUL2) && (cnt_q == CNT_BITS'(CNT_LAST)) && !val_q;

  // Operand and mode selection
  always_comb begin
    mul.ctl      = SQR;
    mul.dat_a    = to_redun(op_q);
    mul.dat_b    = to_redun(op_q);
    mul.add_term = '0;
    if (state_q == MUL1) begin
      // Low half of the square times the factor
      mul.ctl   = MUL_L;
      mul.dat_a = to_redun(i_eq_low);
      mul.dat_b = to_redun(`RM_MONT_FACTOR);
    end else if (state_q == MUL2) begin
      // m times P, high half of the square added on top
      mul.ctl      = MUL_H;
      mul.dat_a    = to_redun(i_eq_low);
      mul.dat_b    = to_redun(`RM_MODULUS);
      mul.add_term = add_q;
    end
  end

  // Final fold of the high product words into binary
  always_comb begin
    lo_sum = '0;
    for (int k = 0; k < N; k++) begin
      lo_sum = lo_sum + ((W*N+1)'(mul.dat[k]) << (k * W));
    end
    // Low words may still spill one unit into the high half
    res = from_redun(mul.dat[2*N-1:N]) + fe_t'(lo_sum[W*N]);
  end

  always_ff @(posedge i_clk) begin
    sq_q <= i_sq;
    // High half of the square, plus one when the low half is nonzero.
    // Word 0 has a clear carry bit here, so the +1 cannot leave it
    if (state_q == MUL1 && cnt_q == CNT_BITS'(CNT_MUL1)) begin
      add_q <= i_eq_dat[2*N-1:N] + redun0_t'(|i_eq_low);
    end
    if (val_q) begin
      op_q <= sq_q;
    end else if (done) begin
      op_q <= res;
    end
    if (done) begin
      o_mul <= res;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      val_q   <= 1'b0;
      o_val   <= 1'b0;
    end else begin
      state_q <= state_d;
      val_q   <= i_val;
      o_val   <= done;
      // Counts cycles since the square issue
      if (state_d == IDLE || state_d == START) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- hdl/redun_mont_defs.svh
`ifndef REDUN_MONT_DEFS_SVH
`define REDUN_MONT_DEFS_SVH

// Meaningful bits in one redundant word, the carry bit comes on top
`define RM_WRD_BITS 8

// Words per operand
`define RM_NUM_WRDS 4

// Binary operand width, R is 2^RM_DAT_BITS
`define RM_DAT_BITS (`RM_WRD_BITS * `RM_NUM_WRDS)

// Odd modulus, kept below R/4 so every result stays under 2P
`define RM_MODULUS 32'h2D97_3801

// -P^-1 mod R
`define RM_MONT_FACTOR 32'h1157_37FF

// Cycles from square issue to result strobe
`define RM_ITER_CYCLES 6

`endif

//--- hdl/redun_mont_pkg.sv
`include "redun_mont_defs.svh"

package redun_mont_pkg;

  // One word, meaningful bits plus a single carry bit
  typedef logic [`RM_WRD_BITS:0] wrd_t;

  // Operand and double-width product, word 0 is least significant
  typedef wrd_t [`RM_NUM_WRDS-1:0] redun0_t;
  typedef wrd_t [2*`RM_NUM_WRDS-1:0] redun1_t;

  // Plain binary value
  typedef logic [`RM_DAT_BITS-1:0] fe_t;

  // Multiplier mode, one-hot
  typedef enum logic [2:0] {
    SQR   = 3'b001,
    MUL_L = 3'b010,
    MUL_H = 3'b100
  } mult_ctl_t;

  // Binary to redundant form with all carry bits clear
  function automatic redun0_t to_redun(input fe_t val);
    redun0_t res;
    for (int i = 0; i < `RM_NUM_WRDS; i++) begin
      res[i] = {1'b0, val[i*`RM_WRD_BITS +: `RM_WRD_BITS]};
    end
    return res;
  endfunction

  // Redundant to binary form, result taken modulo R
  function automatic fe_t from_redun(input redun0_t val);
    fe_t res;
    res = '0;
    for (int i = 0; i < `RM_NUM_WRDS; i++) begin
      res = res + (fe_t'(val[i]) << (i * `RM_WRD_BITS));
    end
    return res;
  endfunction

endpackage

//--- hdl/redun_mont_top.sv
module redun_mont_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  redun_mont_pkg::fe_t i_sq,
  input  logic                i_val,
  output redun_mont_pkg::fe_t o_mul,
  output logic                o_val
);
  import redun_mont_pkg::*;

  redun1_t eq_in;
  redun1_t eq_dat;
  fe_t     eq_low;

  mul_if mul_bus ();

  redun_mont i_redun_mont (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_sq     (i_sq),
    .i_val    (i_val),
    .mul      (mul_bus.seq),
    .i_eq_dat (eq_dat),
    .i_eq_low (eq_low),
    .o_eq_dat (eq_in),
    .o_mul    (o_mul),
    .o_val    (o_val)
  );

  multi_mode_multiplier i_multi_mode_multiplier (
    .i_clk (i_clk),
    .mul   (mul_bus.mult)
  );

  redun_equalizer i_redun_equalizer (
    .i_clk (i_clk),
    .i_dat (eq_in),
    .o_dat (eq_dat),
    .o_low (eq_low)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the squaring engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_redun_mont \
  -f vlog.f -o tb_redun_mont
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_redun_mont > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1

//--- tests/tb_clk_gen.sv
module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #50;
      o_clk = ~o_clk;
    end
  end

  // Reset released shortly after the third rising edge
  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    #10;
    o_rst = 1'b0;
  end

endmodule

//--- tests/tb_redun_mont.sv
`include "redun_mont_defs.svh"

module tb_redun_mont;
  import redun_mont_pkg::*;

  localparam int DB = `RM_DAT_BITS;
  localparam int TIMEOUT = 30;
  // Cycles between result strobes
  localparam int ITER_GAP = 6;
  localparam logic [DB:0] TWO_P = (DB+1)'(`RM_MODULUS) * (DB+1)'(2);

  logic i_clk;
  logic i_rst;
  fe_t  i_sq;
  logic i_val;
  fe_t  o_mul;
  logic o_val;
  int   err_cnt;
  int   fail_cnt;
  int   test_cnt;
  int   seed;

  tb_clk_gen i_tb_clk_gen (
    .o_clk (i_clk),
    .o_rst (i_rst)
  );

  redun_mont_top i_redun_mont_top (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_sq  (i_sq),
    .i_val (i_val),
    .o_mul (o_mul),
    .o_val (o_val)
  );

  // Results are only partly reduced but must stay under 2P
  assert property (@(posedge i_clk) disable iff (i_rst) o_val |-> ({1'b0, o_mul} < TWO_P))
    else begin
      $display("Error at time %0t: o_mul = %h, expected below %h", $time, $sampled(o_mul), TWO_P);
      err_cnt++;
    end

  // (x*x + ((x*x mod R) * F mod R) * P) / R
  function automatic fe_t mont_sqr(input fe_t x);
    logic [2*DB-1:0] sq;
    logic [DB-1:0]   m;
    logic [2*DB:0]   sum;
    sq  = (2*DB)'(x) * (2*DB)'(x);
    m   = sq[DB-1:0] * DB'(`RM_MONT_FACTOR);
    sum = (2*DB+1)'(sq) + (2*DB+1)'(m) * (2*DB+1)'(`RM_MODULUS);
    return sum[2*DB-1:DB];
  endfunction

  task automatic next_cycle();
    @(posedge i_clk);
    #10;
  endtask

  task automatic wait_for_result(output bit found, output int cycles);
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < TIMEOUT) begin
      next_cycle();
      cycles++;
      found = o_val;
    end
    if (!found) begin
      $display("Timeout at time %0t: no o_val within %0d cycles", $time, TIMEOUT);
      err_cnt++;
    end
  endtask

  // Load a value, then follow the chained model for a number of results
  task automatic run_chain(input fe_t start, input int iters, input bit chk_gap);
    fe_t exp;
    bit  found;
    int  cycles;
    exp   = start;
    i_sq  = start;
    i_val = 1'b1;
    next_cycle();
    i_val = 1'b0;
    for (int k = 0; k < iters; k++) begin
      wait_for_result(found, cycles);
      if (!found) begin
        return;
      end
      exp = mont_sqr(exp);
      assert ((o_mul % `RM_MODULUS) == (exp % `RM_MODULUS))
        else begin
          $display("Error at time %0t: o_mul mod P = %h, expected %h", $time,
                   o_mul % `RM_MODULUS, exp % `RM_MODULUS);
          err_cnt++;
        end
      if (chk_gap && k > 0) begin
        assert (cycles == ITER_GAP)
          else begin
            $display("Error at time %0t: o_val gap = %0d, expected %0d", $time,
                     cycles, ITER_GAP);
            err_cnt++;
          end
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("Test %0d %s: PASS", test_cnt, name);
    end else begin
      $display("Test %0d %s: FAIL", test_cnt, name);
      fail_cnt++;
    end
  endtask

  initial begin
    int  err_start;
    fe_t val;
    err_cnt  = 0;
    fail_cnt = 0;
    test_cnt = 0;
    seed     = 32'h1595_1e18;
    i_sq     = '0;
    i_val    = 1'b0;
    repeat (5) next_cycle();

    err_start = err_cnt;
    repeat (20) begin
      next_cycle();
      assert (o_val == 1'b0)
        else begin
          $display("Error at time %0t: o_val = %b, expected 0", $time, o_val);
          err_cnt++;
        end
    end
    report_test("idle after reset", err_start);

    err_start = err_cnt;
    run_chain(32'h0123_4567, 10, 1'b0);
    report_test("ten chained squarings", err_start);

    err_start = err_cnt;
    run_chain(32'h1A2B_3C4D, 6, 1'b1);
    report_test("result spacing", err_start);

    // Restart three cycles into an iteration
    err_start = err_cnt;
    run_chain(32'h0BAD_F00D, 1, 1'b0);
    repeat (3) next_cycle();
    run_chain(32'h2222_1111, 3, 1'b0);
    report_test("restart mid iteration", err_start);

    err_start = err_cnt;
    run_chain(32'h0, 3, 1'b0);
    run_chain(32'h1, 3, 1'b0);
    run_chain(`RM_MODULUS - 1, 3, 1'b0);
    for (int n = 0; n < 20; n++) begin
      val = fe_t'($unsigned($random(seed)) % `RM_MODULUS);
      run_chain(val, 3, 1'b0);
    end
    report_test("edge and random values", err_start);

    // Let the last strobe reach the concurrent check
    repeat (3) next_cycle();
    $display("Tests: %0d run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/redun_mont_pkg.sv
hdl/mul_if.sv
hdl/multi_mode_multiplier.sv
hdl/redun_equalizer.sv
hdl/redun_mont.sv
hdl/redun_mont_top.sv
tests/tb_clk_gen.sv
tests/tb_redun_mont.sv
